// ==== sources.f ====
hdl/ntm_log_pkg.sv
hdl/ntm_exponent_search.sv
hdl/ntm_modular_reducer.sv
hdl/ntm_vector_logarithm.sv
hdl/ntm_logarithm_top.sv
testbench/ntm_logarithm_chk.sv
testbench/ntm_logarithm_tb.sv

// ==== Bender.yml ====
package:
  name: ntm_logarithm

sources:
  # RTL
  - files:
      - hdl/ntm_log_pkg.sv
      - hdl/ntm_exponent_search.sv
      - hdl/ntm_modular_reducer.sv
      - hdl/ntm_vector_logarithm.sv
      - hdl/ntm_logarithm_top.sv

  # Testbench
  - target: test
    files:
      - testbench/ntm_logarithm_chk.sv
      - testbench/ntm_logarithm_tb.sv

// ==== testbench/ntm_logarithm_tb.sv ====
/* Directed tests for the vector logarithm unit against a division based model.
   Needs the bound checker, and the watchdog scales with the element count. */

module ntm_logarithm_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int W           = ntm_log_pkg::DATA_SIZE;
  localparam int CLK_PERIOD  = 8;
  // 2 + 2 + 4 + 8 + 22 elements over the five tests
  localparam int NUM_ELEMS   = 38;
  localparam int ELEM_CYCLES = 100;
  localparam int TIMEOUT_NS  = (NUM_ELEMS * ELEM_CYCLES + 500) * CLK_PERIOD;

  logic         CLK;
  logic         RST;
  logic         START;
  logic [W-1:0] SIZE_IN;
  logic [W-1:0] MODULO_IN;
  logic [W-1:0] DATA_A_IN;
  logic         DATA_A_IN_ENABLE;
  logic [W-1:0] DATA_B_IN;
  logic         DATA_B_IN_ENABLE;
  logic [W-1:0] DATA_OUT;
  logic         DATA_OUT_ENABLE;
  logic         READY;

  // Pending vector elements
  logic [W-1:0] a_q[$];
  logic [W-1:0] b_q[$];
  logic [W-1:0] m_q[$];
  int           ord_q[$];

  int           seed = 32'h3b40;

  ntm_logarithm_top dut_i (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .SIZE_IN          (SIZE_IN),
    .MODULO_IN        (MODULO_IN),
    .DATA_A_IN        (DATA_A_IN),
    .DATA_A_IN_ENABLE (DATA_A_IN_ENABLE),
    .DATA_B_IN        (DATA_B_IN),
    .DATA_B_IN_ENABLE (DATA_B_IN_ENABLE),
    .DATA_OUT         (DATA_OUT),
    .DATA_OUT_ENABLE  (DATA_OUT_ENABLE),
    .READY            (READY)
  );

  initial CLK = 1'b0;
  always #(CLK_PERIOD / 2) CLK = ~CLK;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Drive and sample slot 1 ns past the rising edge
  task automatic step();
    @(posedge CLK);
    #1;
  endtask

  task automatic fail_run(input string msg);
    $display("ERROR: %s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [W-1:0] got,
                             input logic [W-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
      fail_run("output value differs from the expected value");
    end
  endtask

  // floor(log_b a) by repeated division then mod m
  function automatic logic [W-1:0] log_mod_model(input logic [W-1:0] a,
                                                 input logic [W-1:0] b,
                                                 input logic [W-1:0] m);
    logic [W-1:0] v;
    logic [W-1:0] e;
    e = '0;
    if (a != 0 && b >= 2) begin
      v = a;
      while (v >= b) begin
        v = v / b;
        e++;
      end
    end
    if (m != 0) begin
      e = e % m;
    end
    return e;
  endfunction

  task automatic apply_reset();
    RST = 1'b1;
    repeat (16) @(posedge CLK);
    #1;
    RST = 1'b0;
    check_value("READY", READY, '0);
    check_value("DATA_OUT_ENABLE", DATA_OUT_ENABLE, '0);
    check_value("DATA_OUT", DATA_OUT, '0);
  endtask

  task automatic clear_queues();
    a_q.delete();
    b_q.delete();
    m_q.delete();
    ord_q.delete();
  endtask

  // ord 0 together, 1 A first, 2 B first
  task automatic add_element(input logic [W-1:0] a, input logic [W-1:0] b,
                             input logic [W-1:0] m, input int ord);
    a_q.push_back(a);
    b_q.push_back(b);
    m_q.push_back(m);
    ord_q.push_back(ord);
  endtask

  task automatic start_vector(input logic [W-1:0] size);
    SIZE_IN = size;
    START   = 1'b1;
    step();
    START   = 1'b0;
  endtask

  task automatic drive_element(input logic [W-1:0] a, input logic [W-1:0] b,
                               input logic [W-1:0] m, input int ord);
    // Modulus held until the next element
    MODULO_IN = m;
    DATA_A_IN = a;
    DATA_B_IN = b;
    case (ord)
      0: begin
        DATA_A_IN_ENABLE = 1'b1;
        DATA_B_IN_ENABLE = 1'b1;
        step();
      end
      1: begin
        DATA_A_IN_ENABLE = 1'b1;
        step();
        DATA_A_IN_ENABLE = 1'b0;
        DATA_B_IN_ENABLE = 1'b1;
        step();
      end
      default: begin
        DATA_B_IN_ENABLE = 1'b1;
        step();
        DATA_B_IN_ENABLE = 1'b0;
        DATA_A_IN_ENABLE = 1'b1;
        step();
      end
    endcase
    DATA_A_IN_ENABLE = 1'b0;
    DATA_B_IN_ENABLE = 1'b0;
  endtask

  // READY must stay low until the result that ends the vector
  task automatic wait_result(input logic [W-1:0] exp, input logic last);
    int cycles;
    cycles = 0;
    while (!DATA_OUT_ENABLE) begin
      check_value("READY", READY, '0);
      if (cycles == ELEM_CYCLES) begin
        fail_run("no DATA_OUT_ENABLE pulse within the element time limit");
      end else begin
        step();
        cycles++;
      end
    end
    check_value("DATA_OUT", DATA_OUT, exp);
    check_value("READY", READY, last);
  endtask

  task automatic run_vector(input logic [W-1:0] size_in);
    start_vector(size_in);
    for (int i = 0; i < a_q.size(); i++) begin
      drive_element(a_q[i], b_q[i], m_q[i], ord_q[i]);
      wait_result(log_mod_model(a_q[i], b_q[i], m_q[i]), i == a_q.size() - 1);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_exact_powers();
    clear_queues();
    add_element(1024, 2, 0, 0);
    run_vector(1);
    clear_queues();
    add_element(81, 3, 0, 1);
    run_vector(1);
  endtask

  task automatic test_floor_modulus();
    clear_queues();
    add_element(1000, 10, 2, 2);
    run_vector(1);
    clear_queues();
    add_element(999, 10, 5, 0);
    run_vector(1);
  endtask

  task automatic test_special_cases();
    clear_queues();
    add_element(0, 5, 3, 0);
    add_element(100, 1, 0, 1);
    add_element(100, 0, 0, 2);
    add_element(1000, 10, 1, 0);
    run_vector(4);
  endtask

  task automatic test_mixed_order();
    logic [W-1:0] a_tab [8];
    logic [W-1:0] b_tab [8];
    logic [W-1:0] m_tab [8];
    a_tab = '{1, 7, 64, 100000, 4095, 32'hFFFF_FFFF, 625, 32'h0010_0000};
    b_tab = '{2, 7, 4, 10, 16, 2, 5, 3};
    m_tab = '{0, 3, 0, 4, 2, 7, 0, 5};
    clear_queues();
    for (int i = 0; i < 8; i++) begin
      add_element(a_tab[i], b_tab[i], m_tab[i], i % 3);
    end
    run_vector(8);
  endtask

  task automatic add_random_element();
    int           shift;
    logic [W-1:0] a;
    logic [W-1:0] b;
    logic [W-1:0] m;
    int           ord;
    // Random shift spreads argument magnitudes
    shift = $unsigned($random(seed)) % W;
    a     = $unsigned($random(seed)) >> shift;
    b     = $unsigned($random(seed)) % 18;
    m     = $unsigned($random(seed)) % 8;
    ord   = $unsigned($random(seed)) % 3;
    add_element(a, b, m, ord);
  endtask

  task automatic test_random_vector();
    clear_queues();
    repeat (20) add_random_element();
    run_vector(20);
    // Back to back vectors of size 0 run one element each
    clear_queues();
    add_element(4096, 4, 3, 1);
    run_vector(0);
    clear_queues();
    add_random_element();
    run_vector(0);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    RST              = 1'b1;
    START            = 1'b0;
    SIZE_IN          = '0;
    MODULO_IN        = '0;
    DATA_A_IN        = '0;
    DATA_A_IN_ENABLE = 1'b0;
    DATA_B_IN        = '0;
    DATA_B_IN_ENABLE = 1'b0;
    apply_reset();
    test_exact_powers();
    test_floor_modulus();
    test_special_cases();
    test_mixed_order();
    test_random_vector();
    // One more edge so the last READY pulse check completes
    step();
    if (dut_i.chk_i.fail_count == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      fail_run("bound assertions failed during the run");
    end
  end

  initial begin
    #(TIMEOUT_NS);
    fail_run("timeout, the tests did not finish in the allowed time");
  end

endmodule

// ==== testbench/ntm_logarithm_chk.sv ====
/* Concurrent checks on the top-level control pulses.
   Bound into every ntm_logarithm_top instance. */

module ntm_logarithm_chk (
  input logic CLK,
  input logic RST,
  input logic READY,
  input logic DATA_OUT_ENABLE,
  input logic search_start,
  input logic search_done,
  input logic reduce_done
);
  timeunit 1ns;
  timeprecision 100ps;

  // Failed assertions so far
  int fail_count = 0;

  // READY comes with a result
  a_ready_with_out: assert property (@(posedge CLK) disable iff (RST)
    READY |-> DATA_OUT_ENABLE)
    else begin
      fail_count++;
      $error("READY high without DATA_OUT_ENABLE");
    end

  // One cycle pulse
  a_ready_pulse: assert property (@(posedge CLK) disable iff (RST)
    READY |=> !READY)
    else begin
      fail_count++;
      $error("READY held for more than one cycle");
    end

  // Everything quiet while in reset
  a_quiet_in_reset: assert property (@(posedge CLK)
    RST |-> !(READY || DATA_OUT_ENABLE || search_start || search_done || reduce_done))
    else begin
      fail_count++;
      $error("control output high during reset");
    end

endmodule

bind ntm_logarithm_top ntm_logarithm_chk chk_i (
  .CLK             (CLK),
  .RST             (RST),
  .READY           (READY),
  .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
  .search_start    (search_start),
  .search_done     (search_done),
  .reduce_done     (reduce_done)
);

// ==== hdl/ntm_logarithm_top.sv ====
/* One element in flight at a time and no back-pressure.
   Strobes outside the input phase are dropped. */

module ntm_logarithm_top (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              START,
  input  logic [ntm_log_pkg::DATA_SIZE-1:0] SIZE_IN,
  input  logic [ntm_log_pkg::DATA_SIZE-1:0] MODULO_IN,
  input  logic [ntm_log_pkg::DATA_SIZE-1:0] DATA_A_IN,
  input  logic                              DATA_A_IN_ENABLE,
  input  logic [ntm_log_pkg::DATA_SIZE-1:0] DATA_B_IN,
  input  logic                              DATA_B_IN_ENABLE,
  output logic [ntm_log_pkg::DATA_SIZE-1:0] DATA_OUT,
  output logic                              DATA_OUT_ENABLE,
  output logic                              READY
);

  ////////////////////////////////////////
  // Stage links
  ////////////////////////////////////////

  // Sequencer to search
  logic                              search_start;
  logic [ntm_log_pkg::DATA_SIZE-1:0] arg;
  logic [ntm_log_pkg::DATA_SIZE-1:0] base;
  logic [ntm_log_pkg::DATA_SIZE-1:0] modulus;

  // Search to reducer
  logic                              search_done;
  logic [ntm_log_pkg::CNT_SIZE-1:0]  exponent;

  // Reducer back to sequencer
  logic                              reduce_done;
  logic [ntm_log_pkg::CNT_SIZE-1:0]  residue;

  // Stage 1 operand capture and element count
  ntm_vector_logarithm seq_i (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .SIZE_IN          (SIZE_IN),
    .MODULO_IN        (MODULO_IN),
    .DATA_A_IN        (DATA_A_IN),
    .DATA_A_IN_ENABLE (DATA_A_IN_ENABLE),
    .DATA_B_IN        (DATA_B_IN),
    .DATA_B_IN_ENABLE (DATA_B_IN_ENABLE),
    .reduce_done      (reduce_done),
    .residue          (residue),
    .search_start     (search_start),
    .arg              (arg),
    .base             (base),
    .modulus          (modulus),
    .DATA_OUT         (DATA_OUT),
    .DATA_OUT_ENABLE  (DATA_OUT_ENABLE),
    .READY            (READY)
  );

  // Stage 2 exponent search
  ntm_exponent_search srch_i (
    .CLK          (CLK),
    .RST          (RST),
    .search_start (search_start),
    .arg          (arg),
    .base         (base),
    .search_done  (search_done),
    .exponent     (exponent)
  );

  // Stage 3 reduction, started by the search pulse
  ntm_modular_reducer red_i (
    .CLK         (CLK),
    .RST         (RST),
    .search_done (search_done),
    .exponent    (exponent),
    .modulus     (modulus),
    .reduce_done (reduce_done),
    .residue     (residue)
  );

endmodule

// ==== hdl/ntm_vector_logarithm.sv ====
/* START honoured only when idle and SIZE_IN of 0 runs one element.
   MODULO_IN is sampled in the launch cycle of each element. */

module ntm_vector_logarithm (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              START,
  input  logic [ntm_log_pkg::DATA_SIZE-1:0] SIZE_IN,
  input  logic [ntm_log_pkg::DATA_SIZE-1:0] MODULO_IN,
  input  logic [ntm_log_pkg::DATA_SIZE-1:0] DATA_A_IN,
  input  logic                              DATA_A_IN_ENABLE,
  input  logic [ntm_log_pkg::DATA_SIZE-1:0] DATA_B_IN,
  input  logic                              DATA_B_IN_ENABLE,
  input  logic                              reduce_done,
  input  logic [ntm_log_pkg::CNT_SIZE-1:0]  residue,
  output logic                              search_start,
  output logic [ntm_log_pkg::DATA_SIZE-1:0] arg,
  output logic [ntm_log_pkg::DATA_SIZE-1:0] base,
  output logic [ntm_log_pkg::DATA_SIZE-1:0] modulus,
  output logic [ntm_log_pkg::DATA_SIZE-1:0] DATA_OUT,
  output logic                              DATA_OUT_ENABLE,
  output logic                              READY
);

  ////////////////////////////////////////
  // Sequencer state
  ////////////////////////////////////////

  ntm_log_pkg::seq_state_t           state_q;

  // Element index and latched vector length
  logic [ntm_log_pkg::DATA_SIZE-1:0] index_q;
  logic [ntm_log_pkg::DATA_SIZE-1:0] size_q;

  // Operand seen flags for the current element
  logic                              a_seen_q;
  logic                              b_seen_q;

  logic                              launch;
  logic                              take_ops;
  logic                              last_elem;

  // Both operands registered, element goes out next edge
  assign launch = (state_q == ntm_log_pkg::SEQ_INPUT) && a_seen_q && b_seen_q;

  // Strobes land while still collecting
  assign take_ops = (state_q == ntm_log_pkg::SEQ_INPUT) && !launch;

  assign last_elem = (index_q == (size_q - ntm_log_pkg::ONE));

  ////////////////////////////////////////
  // Control path
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q         <= ntm_log_pkg::SEQ_IDLE;
      index_q         <= '0;
      size_q          <= ntm_log_pkg::ONE;
      a_seen_q        <= 1'b0;
      b_seen_q        <= 1'b0;
      search_start    <= 1'b0;
      DATA_OUT        <= '0;
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;
    end else begin
      // Pulses default low
      search_start    <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;

      case (state_q)
        ntm_log_pkg::SEQ_IDLE: begin
          if (START) begin
            // Empty vector still produces one result
            size_q   <= (SIZE_IN == '0) ? ntm_log_pkg::ONE : SIZE_IN;
            index_q  <= '0;
            a_seen_q <= 1'b0;
            b_seen_q <= 1'b0;
            state_q  <= ntm_log_pkg::SEQ_INPUT;
          end
        end

        ntm_log_pkg::SEQ_INPUT: begin
          if (launch) begin
            search_start <= 1'b1;
            a_seen_q     <= 1'b0;
            b_seen_q     <= 1'b0;
            state_q      <= ntm_log_pkg::SEQ_WAIT;
          end else begin
            // Either order, or both at once
            if (DATA_A_IN_ENABLE) begin
              a_seen_q <= 1'b1;
            end
            if (DATA_B_IN_ENABLE) begin
              b_seen_q <= 1'b1;
            end
          end
        end

        ntm_log_pkg::SEQ_WAIT: begin
          // Reducer finished this element
          if (reduce_done) begin
            DATA_OUT <= {{(ntm_log_pkg::DATA_SIZE - ntm_log_pkg::CNT_SIZE){1'b0}},
                         residue};
            DATA_OUT_ENABLE <= 1'b1;
            if (last_elem) begin
              READY   <= 1'b1;
              state_q <= ntm_log_pkg::SEQ_IDLE;
            end else begin
              index_q <= index_q + ntm_log_pkg::ONE;
              state_q <= ntm_log_pkg::SEQ_INPUT;
            end
          end
        end

        default: begin
          state_q <= ntm_log_pkg::SEQ_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Operand registers
  ////////////////////////////////////////

  // Later strobe of the same operand overwrites
  always_ff @(posedge CLK) begin
    if (take_ops && DATA_A_IN_ENABLE) begin
      arg <= DATA_A_IN;
    end
    if (take_ops && DATA_B_IN_ENABLE) begin
      base <= DATA_B_IN;
    end
    // Modulus held for the whole element
    if (launch) begin
      modulus <= MODULO_IN;
    end
  end

endmodule

// ==== hdl/ntm_modular_reducer.sv ====
/* Repeated subtraction, quotient+1 cycles; modulus 0 passes through.
   Modulus must stay stable until reduce_done. */

module ntm_modular_reducer (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              search_done,
  input  logic [ntm_log_pkg::CNT_SIZE-1:0]  exponent,
  input  logic [ntm_log_pkg::DATA_SIZE-1:0] modulus,
  output logic                              reduce_done,
  output logic [ntm_log_pkg::CNT_SIZE-1:0]  residue
);

  ////////////////////////////////////////
  // Reducer state
  ////////////////////////////////////////

  ntm_log_pkg::red_state_t           state_q;
  logic [ntm_log_pkg::CNT_SIZE-1:0]  value_q;

  // Count width views for compare at full modulus width
  logic [ntm_log_pkg::DATA_SIZE-1:0] exp_wide;
  logic [ntm_log_pkg::DATA_SIZE-1:0] val_wide;
  logic [ntm_log_pkg::CNT_SIZE-1:0]  mod_low;

  logic                              bypass;
  logic                              more;

  assign exp_wide = {{(ntm_log_pkg::DATA_SIZE - ntm_log_pkg::CNT_SIZE){1'b0}}, exponent};
  assign val_wide = {{(ntm_log_pkg::DATA_SIZE - ntm_log_pkg::CNT_SIZE){1'b0}}, value_q};

  // Modulus fits the count width whenever a subtraction happens
  assign mod_low = modulus[ntm_log_pkg::CNT_SIZE-1:0];

  // No reduction or already reduced
  assign bypass = (modulus == '0) || (exp_wide < modulus);
  assign more   = (val_wide >= modulus);

  ////////////////////////////////////////
  // Control path
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q     <= ntm_log_pkg::RED_IDLE;
      reduce_done <= 1'b0;
    end else begin
      reduce_done <= 1'b0;
      if (search_done) begin
        if (bypass) begin
          reduce_done <= 1'b1;
        end else begin
          state_q <= ntm_log_pkg::RED_BUSY;
        end
      end else if ((state_q == ntm_log_pkg::RED_BUSY) && !more) begin
        reduce_done <= 1'b1;
        state_q     <= ntm_log_pkg::RED_IDLE;
      end
    end
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (search_done) begin
      // First subtraction taken on the start pulse
      value_q <= exponent - mod_low;
      if (bypass) begin
        residue <= exponent;
      end
    end else if (state_q == ntm_log_pkg::RED_BUSY) begin
      if (more) begin
        value_q <= value_q - mod_low;
      end else begin
        residue <= value_q;
      end
    end
  end

endmodule

// ==== hdl/ntm_exponent_search.sv ====
/* Finds floor(log_base arg) one multiply per cycle, exponent+1 cycles.
   Inputs are captured on search_start and must not change the protocol. */

module ntm_exponent_search (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              search_start,
  input  logic [ntm_log_pkg::DATA_SIZE-1:0] arg,
  input  logic [ntm_log_pkg::DATA_SIZE-1:0] base,
  output logic                              search_done,
  output logic [ntm_log_pkg::CNT_SIZE-1:0]  exponent
);

  ////////////////////////////////////////
  // Search state
  ////////////////////////////////////////

  ntm_log_pkg::srch_state_t              state_q;

  // Captured operands
  logic [ntm_log_pkg::DATA_SIZE-1:0]     arg_q;
  logic [ntm_log_pkg::DATA_SIZE-1:0]     base_q;

  // Power accumulator, double width so the product never wraps
  logic [2*ntm_log_pkg::DATA_SIZE-1:0]   pow_q;
  logic [2*ntm_log_pkg::DATA_SIZE-1:0]   pow_next;
  logic [ntm_log_pkg::CNT_SIZE-1:0]      cnt_q;

  logic                                  quick;
  logic                                  step_ok;

  // Zero exponent known in the start cycle
  assign quick = ntm_log_pkg::log_is_special(arg, base) || (base > arg);

  // Next power still fits under the argument
  assign pow_next = pow_q * {{ntm_log_pkg::DATA_SIZE{1'b0}}, base_q};
  assign step_ok  = (pow_next <= {{ntm_log_pkg::DATA_SIZE{1'b0}}, arg_q});

  ////////////////////////////////////////
  // Control path
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q     <= ntm_log_pkg::SRCH_IDLE;
      search_done <= 1'b0;
    end else begin
      search_done <= 1'b0;
      if (search_start) begin
        if (quick) begin
          search_done <= 1'b1;
        end else begin
          state_q <= ntm_log_pkg::SRCH_BUSY;
        end
      end else if (state_q == ntm_log_pkg::SRCH_BUSY) begin
        // Stop at the first power beyond arg
        if (!step_ok) begin
          search_done <= 1'b1;
          state_q     <= ntm_log_pkg::SRCH_IDLE;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (search_start) begin
      arg_q  <= arg;
      base_q <= base;
      // Accumulator starts at 1, first multiply folded in here
      pow_q  <= {{ntm_log_pkg::DATA_SIZE{1'b0}}, base};
      cnt_q  <= ntm_log_pkg::CNT_ONE;
      if (quick) begin
        exponent <= '0;
      end
    end else if (state_q == ntm_log_pkg::SRCH_BUSY) begin
      if (step_ok) begin
        pow_q <= pow_next;
        cnt_q <= cnt_q + ntm_log_pkg::CNT_ONE;
      end else begin
        exponent <= cnt_q;
      end
    end
  end

endmodule

// ==== hdl/ntm_log_pkg.sv ====
/* Whole design runs at one fixed operand width set here.
   Exponent count covers every power of two up to DATA_SIZE. */

package ntm_log_pkg;

  ////////////////////////////////////////
  // Widths and constants
  ////////////////////////////////////////

  // Operand, modulus, size and result width
  localparam int DATA_SIZE = 32;

  // Exponent count width
  localparam int CNT_SIZE = 6;

  // Smallest base with a meaningful logarithm
  localparam logic [DATA_SIZE-1:0] MIN_BASE = 2;

  // Unit steps for counters
  localparam logic [DATA_SIZE-1:0] ONE     = 1;
  localparam logic [CNT_SIZE-1:0]  CNT_ONE = 1;

  ////////////////////////////////////////
  // State encodings
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    SEQ_IDLE  = 2'd0,
    SEQ_INPUT = 2'd1,
    SEQ_WAIT  = 2'd2
  } seq_state_t;

  typedef enum logic {
    SRCH_IDLE = 1'b0,
    SRCH_BUSY = 1'b1
  } srch_state_t;

  typedef enum logic {
    RED_IDLE = 1'b0,
    RED_BUSY = 1'b1
  } red_state_t;

  // Zero argument or base below two yields exponent 0
  function automatic logic log_is_special(input logic [DATA_SIZE-1:0] a,
                                          input logic [DATA_SIZE-1:0] b);
    return (a == '0) || (b < MIN_BASE);
  endfunction

endpackage
